//--- source/mdf_pkg.sv
package mdf_pkg;

  // Data word and byte address on both bus ports
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;

  // Element count of one job
  typedef logic [15:0] len_t;

  // Right shift applied to the product
  typedef logic [4:0] shift_t;

  // Register window size
  localparam int unsigned N_REGS = 8;
  // Word index bits inside the window
  localparam int unsigned REG_IDX_W = $clog2(N_REGS);

  // Register byte offsets
  localparam addr_t REG_TRIGGER = 32'h00;
  localparam addr_t REG_STATUS  = 32'h04;
  localparam addr_t REG_SRC_A   = 32'h08;
  localparam addr_t REG_SRC_B   = 32'h0C;
  localparam addr_t REG_SRC_C   = 32'h10;
  localparam addr_t REG_DST     = 32'h14;
  localparam addr_t REG_LEN     = 32'h18;
  localparam addr_t REG_SHIFT   = 32'h1C;

  // Job FSM in ctrl
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_START,
    CTRL_RUN
  } ctrl_state_e;

  // Memory port sequencer, READ also covers an idle port during a job
  typedef enum logic [1:0] {
    STRM_IDLE,
    STRM_READ,
    STRM_WRITE
  } strm_state_e;

  // Job setup towards the streamer
  typedef struct packed {
    logic  start;
    addr_t src_a;
    addr_t src_b;
    addr_t src_c;
    addr_t dst;
    len_t  len;
  } ctrl_streamer_t;

  // Streamer status back to ctrl
  typedef struct packed {
    logic done;
  } flags_streamer_t;

endpackage

//--- source/mdf_ctrl.sv
`timescale 1ns/10ps

module mdf_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     periph_req_i,
  input  logic                     periph_we_i,
  input  mdf_pkg::addr_t           periph_add_i,
  input  mdf_pkg::data_t           periph_wdata_i,
  input  mdf_pkg::flags_streamer_t flags_streamer_i,
  output logic                     periph_r_valid_o,
  output mdf_pkg::data_t           periph_r_data_o,
  output mdf_pkg::ctrl_streamer_t  ctrl_streamer_o,
  output mdf_pkg::shift_t          shift_o,
  output logic                     evt_o
);

  mdf_pkg::ctrl_state_e state_q;

  // Job registers
  mdf_pkg::addr_t  src_a_q;
  mdf_pkg::addr_t  src_b_q;
  mdf_pkg::addr_t  src_c_q;
  mdf_pkg::addr_t  dst_q;
  mdf_pkg::len_t   len_q;
  mdf_pkg::shift_t shift_q;

  mdf_pkg::addr_t reg_off;
  mdf_pkg::data_t rdata;
  logic           busy;
  logic           wr_en;
  logic           trigger;

  // Only the low bits select a register, upper address bits alias
  assign reg_off = mdf_pkg::addr_t'(periph_add_i[mdf_pkg::REG_IDX_W+1:0]);

  assign busy    = state_q != mdf_pkg::CTRL_IDLE;
  assign wr_en   = periph_req_i && periph_we_i;
  // Trigger only counts while idle
  assign trigger = wr_en && !busy && reg_off == mdf_pkg::REG_TRIGGER;

  // Job setup is frozen while a job runs
  always_ff @(posedge clk_i) begin
    if (wr_en && !busy) begin
      case (reg_off)
        mdf_pkg::REG_SRC_A: src_a_q <= periph_wdata_i;
        mdf_pkg::REG_SRC_B: src_b_q <= periph_wdata_i;
        mdf_pkg::REG_SRC_C: src_c_q <= periph_wdata_i;
        mdf_pkg::REG_DST:   dst_q   <= periph_wdata_i;
        mdf_pkg::REG_LEN:   len_q   <= mdf_pkg::len_t'(periph_wdata_i);
        mdf_pkg::REG_SHIFT: shift_q <= mdf_pkg::shift_t'(periph_wdata_i);
        default: ;
      endcase
    end
  end

  // Read mux, TRIGGER reads as zero
  always_comb begin
    case (reg_off)
      mdf_pkg::REG_STATUS: rdata = mdf_pkg::data_t'(busy);
      mdf_pkg::REG_SRC_A:  rdata = src_a_q;
      mdf_pkg::REG_SRC_B:  rdata = src_b_q;
      mdf_pkg::REG_SRC_C:  rdata = src_c_q;
      mdf_pkg::REG_DST:    rdata = dst_q;
      mdf_pkg::REG_LEN:    rdata = mdf_pkg::data_t'(len_q);
      mdf_pkg::REG_SHIFT:  rdata = mdf_pkg::data_t'(shift_q);
      default:             rdata = '0;
    endcase
  end

  // Read response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      periph_r_valid_o <= 1'b0;
    end else begin
      periph_r_valid_o <= periph_req_i && !periph_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    periph_r_data_o <= rdata;
  end

  // Job FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mdf_pkg::CTRL_IDLE;
      evt_o   <= 1'b0;
    end else begin
      evt_o <= 1'b0;
      case (state_q)
        mdf_pkg::CTRL_IDLE: begin
          if (trigger) begin
            state_q <= mdf_pkg::CTRL_START;
          end
        end
        // One cycle here gives the start pulse
        mdf_pkg::CTRL_START: state_q <= mdf_pkg::CTRL_RUN;
        mdf_pkg::CTRL_RUN: begin
          // Done becomes the event on the next edge
          if (flags_streamer_i.done) begin
            state_q <= mdf_pkg::CTRL_IDLE;
            evt_o   <= 1'b1;
          end
        end
        default: state_q <= mdf_pkg::CTRL_IDLE;
      endcase
    end
  end

  assign ctrl_streamer_o.start = state_q == mdf_pkg::CTRL_START;
  assign ctrl_streamer_o.src_a = src_a_q;
  assign ctrl_streamer_o.src_b = src_b_q;
  assign ctrl_streamer_o.src_c = src_c_q;
  assign ctrl_streamer_o.dst   = dst_q;
  assign ctrl_streamer_o.len   = len_q;
  assign shift_o               = shift_q;

  // A new job never starts in the cycle the last one reports its end
  start_evt_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ctrl_streamer_o.start && evt_o));

  // Streamer completes only jobs that ctrl has launched
  done_in_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flags_streamer_i.done |-> state_q == mdf_pkg::CTRL_RUN);

endmodule

//--- source/mdf_streamer.sv
`timescale 1ns/10ps

module mdf_streamer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mdf_pkg::ctrl_streamer_t  ctrl_i,
  input  logic                     a_ready_i,
  input  logic                     b_ready_i,
  input  logic                     c_ready_i,
  input  logic                     r_valid_i,
  input  mdf_pkg::data_t           r_data_i,
  input  logic                     tcdm_gnt_i,
  input  logic                     tcdm_r_valid_i,
  input  mdf_pkg::data_t           tcdm_r_data_i,
  output mdf_pkg::flags_streamer_t flags_o,
  output logic                     a_valid_o,
  output mdf_pkg::data_t           a_data_o,
  output logic                     b_valid_o,
  output mdf_pkg::data_t           b_data_o,
  output logic                     c_valid_o,
  output mdf_pkg::data_t           c_data_o,
  output logic                     r_ready_o,
  output logic                     tcdm_req_o,
  output mdf_pkg::addr_t           tcdm_add_o,
  output logic                     tcdm_we_o,
  output mdf_pkg::data_t           tcdm_wdata_o
);

  mdf_pkg::strm_state_e state_q;

  // Operand buffers, slot 0 is A, 1 is B, 2 is C
  logic [2:0]     buf_valid_q;
  mdf_pkg::data_t buf_data_q [3];
  logic [2:0]     buf_ready;
  // Read issued for a slot, data not back yet
  logic [2:0]     inflight_q;
  mdf_pkg::len_t  rd_idx_q [3];
  mdf_pkg::addr_t rd_base [3];
  logic [2:0]     rd_ok;
  // Round-robin pointer over the three streams
  logic [1:0]     rr_q;
  // Stream of the request on the port
  logic [1:0]     sel_q;
  // Stream of the read data due next cycle
  logic [1:0]     ret_sel_q;

  // Result slot and write index
  logic           wr_full_q;
  mdf_pkg::data_t wr_data_q;
  mdf_pkg::len_t  wr_idx_q;

  // Memory request register
  logic           req_q;
  mdf_pkg::addr_t add_q;
  mdf_pkg::data_t wdata_q;
  logic           done_q;

  logic port_free;
  logic issue_wr;
  logic issue_rd;
  logic rd_gnt;
  logic last_wr;

  assign rd_base[0] = ctrl_i.src_a;
  assign rd_base[1] = ctrl_i.src_b;
  assign rd_base[2] = ctrl_i.src_c;
  assign buf_ready  = {c_ready_i, b_ready_i, a_ready_i};

  // Port takes a new request when empty or granted now
  assign port_free = !req_q || tcdm_gnt_i;
  assign rd_gnt    = req_q && tcdm_gnt_i && state_q == mdf_pkg::STRM_READ;
  // Write index already counts the write being granted
  assign last_wr   = state_q == mdf_pkg::STRM_WRITE && tcdm_gnt_i && wr_idx_q == ctrl_i.len;

  // Room for a read: buffer empty or draining this cycle, none in flight
  always_comb begin
    for (int s = 0; s < 3; s++) begin
      rd_ok[s] = !inflight_q[s] && (!buf_valid_q[s] || buf_ready[s]) &&
                 rd_idx_q[s] != ctrl_i.len;
    end
  end

  // Pending result write wins over new reads
  assign issue_wr = state_q != mdf_pkg::STRM_IDLE && port_free && wr_full_q;
  assign issue_rd = state_q != mdf_pkg::STRM_IDLE && port_free && !wr_full_q && rd_ok[rr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= mdf_pkg::STRM_IDLE;
      req_q       <= 1'b0;
      buf_valid_q <= '0;
      inflight_q  <= '0;
      rd_idx_q    <= '{default: '0};
      rr_q        <= '0;
      sel_q       <= '0;
      ret_sel_q   <= '0;
      wr_full_q   <= 1'b0;
      wr_idx_q    <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // Operands taken by the engine
      buf_valid_q <= buf_valid_q & ~buf_ready;
      // Read data lands in the slot that asked for it
      if (tcdm_r_valid_i) begin
        buf_valid_q[ret_sel_q] <= 1'b1;
        inflight_q[ret_sel_q]  <= 1'b0;
      end
      if (r_valid_i && r_ready_o) begin
        wr_full_q <= 1'b1;
      end
      if (port_free) begin
        req_q <= issue_wr || issue_rd;
        if (issue_wr) begin
          state_q   <= mdf_pkg::STRM_WRITE;
          wr_full_q <= 1'b0;
          wr_idx_q  <= wr_idx_q + 16'd1;
        end else if (state_q != mdf_pkg::STRM_IDLE) begin
          state_q <= mdf_pkg::STRM_READ;
        end
        if (issue_rd) begin
          inflight_q[rr_q] <= 1'b1;
          rd_idx_q[rr_q]   <= rd_idx_q[rr_q] + 16'd1;
          sel_q            <= rr_q;
          rr_q             <= (rr_q == 2'd2) ? 2'd0 : rr_q + 2'd1;
        end
      end
      if (rd_gnt) begin
        ret_sel_q <= sel_q;
      end
      // Job ends with the grant of the last write
      if (last_wr) begin
        state_q <= mdf_pkg::STRM_IDLE;
        done_q  <= 1'b1;
      end
      if (ctrl_i.start) begin
        rd_idx_q <= '{default: '0};
        wr_idx_q <= '0;
        rr_q     <= '0;
        // Empty job finishes at once
        if (ctrl_i.len == '0) begin
          done_q <= 1'b1;
        end else begin
          state_q <= mdf_pkg::STRM_READ;
        end
      end
    end
  end

  // Payload path
  always_ff @(posedge clk_i) begin
    if (tcdm_r_valid_i) begin
      buf_data_q[ret_sel_q] <= tcdm_r_data_i;
    end
    if (r_valid_i && r_ready_o) begin
      wr_data_q <= r_data_i;
    end
    if (issue_wr) begin
      add_q   <= ctrl_i.dst + mdf_pkg::addr_t'({wr_idx_q, 2'b00});
      wdata_q <= wr_data_q;
    end else if (issue_rd) begin
      add_q <= rd_base[rr_q] + mdf_pkg::addr_t'({rd_idx_q[rr_q], 2'b00});
    end
  end

  assign a_valid_o    = buf_valid_q[0];
  assign a_data_o     = buf_data_q[0];
  assign b_valid_o    = buf_valid_q[1];
  assign b_data_o     = buf_data_q[1];
  assign c_valid_o    = buf_valid_q[2];
  assign c_data_o     = buf_data_q[2];
  assign r_ready_o    = !wr_full_q;
  assign tcdm_req_o   = req_q;
  assign tcdm_add_o   = add_q;
  assign tcdm_we_o    = state_q == mdf_pkg::STRM_WRITE;
  assign tcdm_wdata_o = wdata_q;
  assign flags_o.done = done_q;

  // Request and its fields hold until the memory grants
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o && $stable(tcdm_add_o) &&
    $stable(tcdm_we_o) && $stable(tcdm_wdata_o));

  // Memory answers only granted reads
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_r_valid_i |-> $past(tcdm_req_o && tcdm_gnt_i && !tcdm_we_o));

endmodule

//--- source/mdf_engine.sv
`timescale 1ns/10ps

module mdf_engine (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  mdf_pkg::shift_t shift_i,
  input  logic            a_valid_i,
  input  mdf_pkg::data_t  a_data_i,
  input  logic            b_valid_i,
  input  mdf_pkg::data_t  b_data_i,
  input  logic            c_valid_i,
  input  mdf_pkg::data_t  c_data_i,
  input  logic            r_ready_i,
  output logic            a_ready_o,
  output logic            b_ready_o,
  output logic            c_ready_o,
  output logic            r_valid_o,
  output mdf_pkg::data_t  r_data_o
);

  logic           stall;
  logic           fire;
  logic           s1_valid_q;
  mdf_pkg::data_t prod;
  // Stage one holds product and addend
  mdf_pkg::data_t s1_prod_q;
  mdf_pkg::data_t s1_c_q;

  // Held output blocks both stages
  assign stall = r_valid_o && !r_ready_i;
  // All three operands consumed together
  assign fire  = a_valid_i && b_valid_i && c_valid_i && !stall;

  assign a_ready_o = fire;
  assign b_ready_o = fire;
  assign c_ready_o = fire;

  // Low word of the signed product, wraps
  assign prod = mdf_pkg::data_t'($signed(a_data_i) * $signed(b_data_i));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      r_valid_o  <= 1'b0;
    end else if (!stall) begin
      s1_valid_q <= fire;
      r_valid_o  <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      if (fire) begin
        s1_prod_q <= prod;
        s1_c_q    <= c_data_i;
      end
      // Arithmetic shift keeps the sign
      if (s1_valid_q) begin
        r_data_o <= mdf_pkg::data_t'($signed(s1_prod_q) >>> shift_i) + s1_c_q;
      end
    end
  end

  // Result held steady under backpressure
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

//--- source/mdf_top.sv
`timescale 1ns/10ps

module mdf_top (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Peripheral slave port
  input  logic           periph_req_i,
  input  logic           periph_we_i,
  input  mdf_pkg::addr_t periph_add_i,
  input  mdf_pkg::data_t periph_wdata_i,
  output logic           periph_r_valid_o,
  output mdf_pkg::data_t periph_r_data_o,
  // Memory master port
  output logic           tcdm_req_o,
  input  logic           tcdm_gnt_i,
  output mdf_pkg::addr_t tcdm_add_o,
  output logic           tcdm_we_o,
  output mdf_pkg::data_t tcdm_wdata_o,
  input  logic           tcdm_r_valid_i,
  input  mdf_pkg::data_t tcdm_r_data_i,
  // Job end event
  output logic           evt_o
);

  mdf_pkg::ctrl_streamer_t  streamer_ctrl;
  mdf_pkg::flags_streamer_t streamer_flags;
  mdf_pkg::shift_t          shift;

  // Operand streams, streamer to engine
  logic           a_valid;
  logic           a_ready;
  mdf_pkg::data_t a_data;
  logic           b_valid;
  logic           b_ready;
  mdf_pkg::data_t b_data;
  logic           c_valid;
  logic           c_ready;
  mdf_pkg::data_t c_data;
  // Result stream, engine to streamer
  logic           r_valid;
  logic           r_ready;
  mdf_pkg::data_t r_data;

  mdf_ctrl u_ctrl (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .periph_req_i     ( periph_req_i     ),
    .periph_we_i      ( periph_we_i      ),
    .periph_add_i     ( periph_add_i     ),
    .periph_wdata_i   ( periph_wdata_i   ),
    .flags_streamer_i ( streamer_flags   ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .periph_r_data_o  ( periph_r_data_o  ),
    .ctrl_streamer_o  ( streamer_ctrl    ),
    .shift_o          ( shift            ),
    .evt_o            ( evt_o            )
  );

  mdf_streamer u_streamer (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ctrl_i         ( streamer_ctrl  ),
    .a_ready_i      ( a_ready        ),
    .b_ready_i      ( b_ready        ),
    .c_ready_i      ( c_ready        ),
    .r_valid_i      ( r_valid        ),
    .r_data_i       ( r_data         ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .tcdm_r_data_i  ( tcdm_r_data_i  ),
    .flags_o        ( streamer_flags ),
    .a_valid_o      ( a_valid        ),
    .a_data_o       ( a_data         ),
    .b_valid_o      ( b_valid        ),
    .b_data_o       ( b_data         ),
    .c_valid_o      ( c_valid        ),
    .c_data_o       ( c_data         ),
    .r_ready_o      ( r_ready        ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_we_o      ( tcdm_we_o      ),
    .tcdm_wdata_o   ( tcdm_wdata_o   )
  );

  mdf_engine u_engine (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .shift_i   ( shift   ),
    .a_valid_i ( a_valid ),
    .a_data_i  ( a_data  ),
    .b_valid_i ( b_valid ),
    .b_data_i  ( b_data  ),
    .c_valid_i ( c_valid ),
    .c_data_i  ( c_data  ),
    .r_ready_i ( r_ready ),
    .a_ready_o ( a_ready ),
    .b_ready_o ( b_ready ),
    .c_ready_o ( c_ready ),
    .r_valid_o ( r_valid ),
    .r_data_o  ( r_data  )
  );

endmodule

//--- sim/tb_tcdm_mem.sv
`timescale 1ns/10ps

module tb_tcdm_mem (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic [31:0] add_i,
  input  logic        we_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        r_valid_o,
  output logic [31:0] r_data_o
);

  localparam int unsigned DEPTH = 1024;

  // Word storage, loaded by the testbench
  logic [31:0] mem [DEPTH];
  logic [31:0] lcg_q;
  logic [31:0] lcg_nxt;
  // Wait cycles left before the pending request is granted
  logic [1:0]  delay_q;
  logic [9:0]  idx;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word index, byte offset dropped
  assign idx     = add_i[11:2];
  assign lcg_nxt = lcg_next(lcg_q);
  // Unknown request before reset counts as idle
  assign gnt_o   = (req_i === 1'b1) && delay_q == 2'd0;

  initial begin
    r_valid_o = 1'b0;
    r_data_o  = '0;
    delay_q   = '0;
    lcg_q     = 32'd17;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      lcg_q     <= 32'd17;
      delay_q   <= 2'd0;
      r_valid_o <= 1'b0;
    end else begin
      // Read data one cycle after the grant
      r_valid_o <= gnt_o && !we_i;
      if (gnt_o) begin
        // Draw the wait for the next request, 0 to 3 cycles
        lcg_q   <= lcg_nxt;
        delay_q <= lcg_nxt[31:30];
        if (we_i) begin
          mem[idx] <= wdata_i;
        end else begin
          r_data_o <= mem[idx];
        end
      end else if (req_i && delay_q != 2'd0) begin
        delay_q <= delay_q - 2'd1;
      end
    end
  end

endmodule

//--- sim/tb_mdf_top.sv
`timescale 1ns/10ps

module tb_mdf_top;

  // Elements over all jobs, four accesses each of up to four cycles
  localparam int TOTAL_ELEMS     = 38;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMS * 4 * 4 + 2000;

  logic        clk;
  logic        rst_n;
  logic        periph_req;
  logic        periph_we;
  logic [31:0] periph_add;
  logic [31:0] periph_wdata;
  logic        periph_r_valid;
  logic [31:0] periph_r_data;
  logic        tcdm_req;
  logic        tcdm_gnt;
  logic [31:0] tcdm_add;
  logic        tcdm_we;
  logic [31:0] tcdm_wdata;
  logic        tcdm_r_valid;
  logic [31:0] tcdm_r_data;
  logic        evt;

  int          value_errs = 0;
  int          other_errs = 0;
  int          evt_count  = 0;
  int          mem_writes = 0;
  logic [31:0] rng;

  mdf_top u_mdf_top (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .periph_req_i     ( periph_req     ),
    .periph_we_i      ( periph_we      ),
    .periph_add_i     ( periph_add     ),
    .periph_wdata_i   ( periph_wdata   ),
    .periph_r_valid_o ( periph_r_valid ),
    .periph_r_data_o  ( periph_r_data  ),
    .tcdm_req_o       ( tcdm_req       ),
    .tcdm_gnt_i       ( tcdm_gnt       ),
    .tcdm_add_o       ( tcdm_add       ),
    .tcdm_we_o        ( tcdm_we        ),
    .tcdm_wdata_o     ( tcdm_wdata     ),
    .tcdm_r_valid_i   ( tcdm_r_valid   ),
    .tcdm_r_data_i    ( tcdm_r_data    ),
    .evt_o            ( evt            )
  );

  tb_tcdm_mem u_mem (
    .clk_i     ( clk          ),
    .rst_n_i   ( rst_n        ),
    .req_i     ( tcdm_req     ),
    .add_i     ( tcdm_add     ),
    .we_i      ( tcdm_we      ),
    .wdata_i   ( tcdm_wdata   ),
    .gnt_o     ( tcdm_gnt     ),
    .r_valid_o ( tcdm_r_valid ),
    .r_data_o  ( tcdm_r_data  )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Event pulses and granted writes, sampled mid-cycle
  always @(negedge clk) begin
    if (evt) begin
      evt_count++;
    end
    if (tcdm_req && tcdm_gnt && tcdm_we) begin
      mem_writes++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the DUT hung and the run was stopped");
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Background word, unique per index
  function automatic logic [31:0] fill_word(input int idx);
    return 32'hF00D_0000 | idx;
  endfunction

  // Low word of the signed product, arithmetic shift, then add C
  function automatic logic [31:0] expected_result(input logic [31:0] a, b, c,
                                                  input logic [4:0] sh);
    logic signed [63:0] full;
    logic signed [31:0] low;
    logic signed [31:0] shifted;
    full    = $signed(a) * $signed(b);
    low     = full[31:0];
    // Sign fill happens here, before C joins the sum
    shifted = low >>> sh;
    return shifted + c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, data);
    @(posedge clk);
    periph_req   <= 1'b1;
    periph_we    <= 1'b1;
    periph_add   <= addr;
    periph_wdata <= data;
    @(posedge clk);
    periph_req <= 1'b0;
    periph_we  <= 1'b0;
  endtask

  // Response comes exactly one cycle after the request
  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    periph_req <= 1'b1;
    periph_we  <= 1'b0;
    periph_add <= addr;
    @(posedge clk);
    periph_req <= 1'b0;
    @(negedge clk);
    assert (periph_r_valid) else begin
      $display("Read response missing one cycle after the request to 0x%0h", addr);
      other_errs++;
    end
    data = periph_r_data;
  endtask

  task automatic wait_evt(input int max_cycles, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!evt && cycles < max_cycles);
    assert (evt) else begin
      $display("Timed out after %0d cycles waiting for the job end event", cycles);
      other_errs++;
    end
  endtask

  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
      u_mem.mem[i] = fill_word(i);
    end
  endtask

  // Word indices into the memory model
  task automatic setup_job(input int a_w, b_w, c_w, d_w, len, input logic [4:0] sh);
    reg_write(mdf_pkg::REG_SRC_A, a_w * 4);
    reg_write(mdf_pkg::REG_SRC_B, b_w * 4);
    reg_write(mdf_pkg::REG_SRC_C, c_w * 4);
    reg_write(mdf_pkg::REG_DST, d_w * 4);
    reg_write(mdf_pkg::REG_LEN, len);
    reg_write(mdf_pkg::REG_SHIFT, {27'd0, sh});
  endtask

  task automatic check_job(input int a_w, b_w, c_w, d_w, len, input logic [4:0] sh);
    logic [31:0] exp;
    for (int i = 0; i < len; i++) begin
      exp = expected_result(u_mem.mem[a_w+i], u_mem.mem[b_w+i], u_mem.mem[c_w+i], sh);
      check_value($sformatf("mem[%0d]", d_w + i), u_mem.mem[d_w+i], exp);
    end
  endtask

  task automatic check_register_access();
    logic [31:0] rd;
    logic [31:0] offs [6];
    logic [31:0] vals [6];
    logic [31:0] masks [6];
    offs  = '{mdf_pkg::REG_SRC_A, mdf_pkg::REG_SRC_B, mdf_pkg::REG_SRC_C,
              mdf_pkg::REG_DST, mdf_pkg::REG_LEN, mdf_pkg::REG_SHIFT};
    vals  = '{32'h0000_1000, 32'h0000_2004, 32'h0000_3008,
              32'hABCD_0010, 32'h0001_1234, 32'h0000_00E5};
    // LEN keeps 16 bits, SHIFT keeps 5
    masks = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
              32'hFFFF_FFFF, 32'h0000_FFFF, 32'h0000_001F};
    reg_read(mdf_pkg::REG_STATUS, rd);
    check_value("periph_r_data_o STATUS", rd, 32'h0);
    for (int i = 0; i < 6; i++) begin
      reg_write(offs[i], vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      reg_read(offs[i], rd);
      check_value($sformatf("periph_r_data_o @0x%0h", offs[i]), rd, vals[i] & masks[i]);
    end
  endtask

  task automatic run_fixed_job();
    logic [31:0] a [4];
    logic [31:0] b [4];
    logic [31:0] c [4];
    logic [31:0] exp [4];
    int          start;
    int          cycles;
    a   = '{32'd3, -32'sd5, 32'h7FFF_FFFF, -32'sd1};
    b   = '{32'd4, 32'd6, 32'd2, -32'sd7};
    c   = '{32'd1, 32'd10, -32'sd3, 32'd100};
    // Hand-worked A*B+C, third one wraps
    exp = '{32'h0000_000D, 32'hFFFF_FFEC, 32'hFFFF_FFFB, 32'h0000_006B};
    for (int i = 0; i < 4; i++) begin
      u_mem.mem[i]      = a[i];
      u_mem.mem[16 + i] = b[i];
      u_mem.mem[32 + i] = c[i];
    end
    setup_job(0, 16, 32, 48, 4, 5'd0);
    start = evt_count;
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    wait_evt(4 * 16 + 40, cycles);
    @(negedge clk);
    assert (!evt) else begin
      $display("Job end event stayed high longer than one cycle");
      other_errs++;
    end
    repeat (10) @(negedge clk);
    assert (evt_count == start + 1) else begin
      $display("Job end event pulsed %0d times instead of once", evt_count - start);
      other_errs++;
    end
    for (int i = 0; i < 4; i++) begin
      check_value($sformatf("mem[%0d]", 48 + i), u_mem.mem[48+i], exp[i]);
    end
  endtask

  task automatic run_random_job();
    int cycles;
    for (int i = 0; i < 16; i++) begin
      rng = lcg_next(rng);
      u_mem.mem[64 + i] = rng;
      rng = lcg_next(rng);
      u_mem.mem[96 + i] = rng;
      rng = lcg_next(rng);
      u_mem.mem[128 + i] = rng;
    end
    setup_job(64, 96, 128, 160, 16, 5'd7);
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    wait_evt(16 * 16 + 40, cycles);
    repeat (2) @(negedge clk);
    check_job(64, 96, 128, 160, 16, 5'd7);
    // Guard words past the destination
    check_value("mem[176]", u_mem.mem[176], fill_word(176));
    check_value("mem[177]", u_mem.mem[177], fill_word(177));
  endtask

  task automatic run_retrigger_job();
    logic [31:0] rd;
    int          start;
    int          writes;
    int          cycles;
    setup_job(64, 96, 128, 192, 8, 5'd3);
    start  = evt_count;
    writes = mem_writes;
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    reg_read(mdf_pkg::REG_STATUS, rd);
    check_value("periph_r_data_o STATUS", rd, 32'h1);
    // Second trigger lands mid-job
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    reg_read(mdf_pkg::REG_STATUS, rd);
    check_value("periph_r_data_o STATUS", rd, 32'h1);
    wait_evt(8 * 16 + 40, cycles);
    reg_read(mdf_pkg::REG_STATUS, rd);
    check_value("periph_r_data_o STATUS", rd, 32'h0);
    repeat (40) @(negedge clk);
    assert (evt_count == start + 1 && mem_writes == writes + 8) else begin
      $display("Trigger during a busy job was not ignored, %0d events and %0d writes",
               evt_count - start, mem_writes - writes);
      other_errs++;
    end
    check_job(64, 96, 128, 192, 8, 5'd3);
  endtask

  task automatic run_empty_and_back_to_back();
    int writes;
    int cycles;
    setup_job(64, 96, 128, 300, 0, 5'd0);
    writes = mem_writes;
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    wait_evt(20, cycles);
    // Third falling edge is two cycles after the trigger edge
    assert (cycles == 3) else begin
      $display("Empty job ended after %0d cycles instead of two", cycles - 1);
      other_errs++;
    end
    repeat (3) @(negedge clk);
    assert (mem_writes == writes) else begin
      $display("Empty job wrote %0d words to memory", mem_writes - writes);
      other_errs++;
    end
    setup_job(64, 96, 128, 224, 5, 5'd1);
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    wait_evt(5 * 16 + 40, cycles);
    // Reprogram right after the event
    setup_job(64, 96, 128, 256, 5, 5'd4);
    reg_write(mdf_pkg::REG_TRIGGER, 32'h1);
    wait_evt(5 * 16 + 40, cycles);
    repeat (2) @(negedge clk);
    check_job(64, 96, 128, 224, 5, 5'd1);
    check_job(64, 96, 128, 256, 5, 5'd4);
  endtask

  initial begin
    periph_req   = 1'b0;
    periph_we    = 1'b0;
    periph_add   = '0;
    periph_wdata = '0;
    rst_n        = 1'b0;
    rng          = 32'd17;
    fill_memory();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_register_access();
    run_fixed_job();
    run_random_job();
    run_retrigger_job();
    run_empty_and_back_to_back();
    repeat (5) @(posedge clk);
    $display("Checks done with %0d value errors and %0d other errors",
             value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
source/mdf_pkg.sv
source/mdf_ctrl.sv
source/mdf_streamer.sv
source/mdf_engine.sv
source/mdf_top.sv
sim/tb_tcdm_mem.sv
sim/tb_mdf_top.sv
